// File: dmc_pkg.sv
package dmc_pkg;

  localparam int NUM_BANKS_LP   = 4;
  localparam int BANK_W_LP      = 2;
  localparam int ROW_W_LP       = 12;
  localparam int COL_W_LP       = 8;
  localparam int DATA_W_LP      = 32;
  localparam int ADDR_W_LP      = BANK_W_LP + ROW_W_LP + COL_W_LP;
  localparam int ORDER_DEPTH_LP = 4;
  localparam int ORDER_PTR_W_LP = $clog2(ORDER_DEPTH_LP);
  localparam int AXIL_ADDR_W_LP = 4;
  localparam int RD_PIPE_LP     = 16;

  localparam logic [1:0] AXI_RESP_OKAY_LP   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR_LP = 2'b10;

  // Column in the low bits, then bank, row on top
  typedef logic [ADDR_W_LP-1:0] app_addr_t;
  typedef logic [BANK_W_LP-1:0] bank_t;
  typedef logic [ROW_W_LP-1:0]  row_t;
  typedef logic [COL_W_LP-1:0]  col_t;
  typedef logic [DATA_W_LP-1:0] data_t;
  typedef logic [3:0]           tick_t;
  typedef logic [15:0]          refi_t;

  typedef enum logic [2:0] {
    APP_CMD_WRITE = 3'b000,
    APP_CMD_READ  = 3'b001
  } app_cmd_e;

  // Encoded as {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    DDR_NOP   = 3'b111,
    DDR_ACT   = 3'b011,
    DDR_READ  = 3'b101,
    DDR_WRITE = 3'b100,
    DDR_PRE   = 3'b010,
    DDR_REF   = 3'b001
  } ddr_cmd_e;

  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_ACTIVATING,
    BANK_ACTIVE,
    BANK_PRECHARGING
  } bank_state_e;

  typedef struct packed {
    tick_t trcd;
    tick_t trp;
    tick_t tras;
    tick_t tcas;
    tick_t trfc;
    refi_t trefi;
  } dmc_timing_s;

  typedef struct packed {
    app_cmd_e cmd;
    row_t     row;
    col_t     col;
    data_t    data;
  } bank_req_s;

  typedef struct packed {
    logic     valid;
    ddr_cmd_e cmd;
    bank_t    bank;
    row_t     row;
    col_t     col;
    data_t    data;
  } bank_cmd_s;

  typedef struct packed {
    ddr_cmd_e cmd;
    bank_t    ba;
    row_t     addr;
    data_t    dq;
    logic     wr_en;
  } ddr_bus_s;

  localparam dmc_timing_s TIMING_RST_LP = '{
    trcd:  4'd3,
    trp:   4'd3,
    tras:  4'd6,
    tcas:  4'd3,
    trfc:  4'd8,
    trefi: 16'd200
  };

  // Count minus one, held at zero
  function automatic tick_t tick_dec(tick_t t);
    return (t == '0) ? '0 : t - 1'b1;
  endfunction

endpackage

// File: dmc_cfg_regs.sv
`timescale 1ns/1ps

module dmc_cfg_regs
  import dmc_pkg::*;
(
  input  logic                      dfi_clk_1x,
  input  logic                      ui_clk_sync_rst,
  input  logic [AXIL_ADDR_W_LP-1:0] s_axil_awaddr_i,
  input  logic                      s_axil_awvalid_i,
  output logic                      s_axil_awready_o,
  input  data_t                     s_axil_wdata_i,
  input  logic                      s_axil_wvalid_i,
  output logic                      s_axil_wready_o,
  output logic [1:0]                s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  logic                      s_axil_bready_i,
  input  logic [AXIL_ADDR_W_LP-1:0] s_axil_araddr_i,
  input  logic                      s_axil_arvalid_i,
  output logic                      s_axil_arready_o,
  output data_t                     s_axil_rdata_o,
  output logic [1:0]                s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  logic                      s_axil_rready_i,
  output dmc_timing_s               timing_o
);

  dmc_timing_s timing_q;
  logic        wr_fire;
  logic        rd_fire;
  logic        wr_hit;
  logic        rd_hit;
  data_t       rd_word;

  // Address and data taken together, one response outstanding
  assign wr_fire          = s_axil_awvalid_i & s_axil_wvalid_i & ~s_axil_bvalid_o;
  assign s_axil_awready_o = wr_fire;
  assign s_axil_wready_o  = wr_fire;
  assign s_axil_arready_o = ~s_axil_rvalid_o;
  assign rd_fire          = s_axil_arvalid_i & s_axil_arready_o;

  // Unaligned offsets are unmapped
  assign wr_hit = (s_axil_awaddr_i[1:0] == 2'b00);
  assign rd_hit = (s_axil_araddr_i[1:0] == 2'b00);

  always_comb begin
    rd_word = '0;
    case (s_axil_araddr_i[AXIL_ADDR_W_LP-1:2])
      2'd0:    rd_word[7:0]  = {timing_q.trp, timing_q.trcd};
      2'd1:    rd_word[7:0]  = {timing_q.tcas, timing_q.tras};
      2'd2:    rd_word[3:0]  = timing_q.trfc;
      default: rd_word[15:0] = timing_q.trefi;
    endcase
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (ui_clk_sync_rst) begin
      timing_q <= TIMING_RST_LP;
    end else if (wr_fire && wr_hit) begin
      case (s_axil_awaddr_i[AXIL_ADDR_W_LP-1:2])
        2'd0: begin
          timing_q.trcd <= s_axil_wdata_i[3:0];
          timing_q.trp  <= s_axil_wdata_i[7:4];
        end
        2'd1: begin
          timing_q.tras <= s_axil_wdata_i[3:0];
          timing_q.tcas <= s_axil_wdata_i[7:4];
        end
        2'd2:    timing_q.trfc  <= s_axil_wdata_i[3:0];
        default: timing_q.trefi <= s_axil_wdata_i[15:0];
      endcase
    end
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (ui_clk_sync_rst) begin
      s_axil_bvalid_o <= 1'b0;
      s_axil_rvalid_o <= 1'b0;
    end else begin
      if (wr_fire) begin
        s_axil_bvalid_o <= 1'b1;
      end else if (s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;
      end
      if (rd_fire) begin
        s_axil_rvalid_o <= 1'b1;
      end else if (s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (wr_fire) begin
      s_axil_bresp_o <= wr_hit ? AXI_RESP_OKAY_LP : AXI_RESP_SLVERR_LP;
    end
    if (rd_fire) begin
      s_axil_rdata_o <= rd_hit ? rd_word : '0;
      s_axil_rresp_o <= rd_hit ? AXI_RESP_OKAY_LP : AXI_RESP_SLVERR_LP;
    end
  end

  assign timing_o = timing_q;

endmodule

// File: dmc_cmd_dispatch.sv
`timescale 1ns/1ps

module dmc_cmd_dispatch
  import dmc_pkg::*;
(
  input  logic                    dfi_clk_1x,
  input  logic                    ui_clk_sync_rst,
  input  app_addr_t               app_addr_i,
  input  app_cmd_e                app_cmd_i,
  input  logic                    app_en_i,
  input  data_t                   app_wdf_data_i,
  output logic                    app_rdy_o,
  input  logic                    ref_pending_i,
  input  logic [NUM_BANKS_LP-1:0] bank_busy_i,
  output logic [NUM_BANKS_LP-1:0] bank_load_o,
  output bank_req_s               bank_req_o,
  input  logic                    order_pop_i,
  output bank_t                   order_head_o,
  output logic                    order_empty_o
);

  bank_t                     addr_bank;
  logic                      run_q;
  logic                      accept;
  logic                      order_full;
  bank_t                     order_mem [ORDER_DEPTH_LP];
  logic [ORDER_PTR_W_LP-1:0] wr_ptr_q;
  logic [ORDER_PTR_W_LP-1:0] rd_ptr_q;
  logic [ORDER_PTR_W_LP:0]   count_q;

  assign addr_bank       = app_addr_i[COL_W_LP +: BANK_W_LP];
  assign bank_req_o.cmd  = app_cmd_i;
  assign bank_req_o.row  = app_addr_i[COL_W_LP+BANK_W_LP +: ROW_W_LP];
  assign bank_req_o.col  = app_addr_i[COL_W_LP-1:0];
  assign bank_req_o.data = app_wdf_data_i;

  assign order_full = (count_q == (ORDER_PTR_W_LP+1)'(ORDER_DEPTH_LP));
  assign app_rdy_o  = run_q & ~bank_busy_i[addr_bank] & ~order_full & ~ref_pending_i;
  assign accept     = app_en_i & app_rdy_o;

  always_comb begin
    bank_load_o            = '0;
    bank_load_o[addr_bank] = accept;
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (ui_clk_sync_rst) begin
      run_q    <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      run_q <= 1'b1;
      if (accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (order_pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({accept, order_pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Issue order of column commands
  always_ff @(posedge dfi_clk_1x) begin
    if (accept) begin
      order_mem[wr_ptr_q] <= addr_bank;
    end
  end

  assign order_head_o  = order_mem[rd_ptr_q];
  assign order_empty_o = (count_q == '0);

endmodule

// File: dmc_bank_machine.sv
`timescale 1ns/1ps

module dmc_bank_machine
  import dmc_pkg::*;
#(
  parameter int unsigned BANK_ID = 0
) (
  input  logic        dfi_clk_1x,
  input  logic        ui_clk_sync_rst,
  input  dmc_timing_s timing_i,
  input  logic        load_i,
  input  bank_req_s   req_i,
  input  logic        ref_pending_i,
  input  logic        grant_i,
  output logic        busy_o,
  output logic        idle_o,
  output bank_cmd_s   cmd_o
);

  bank_state_e state_q;
  row_t        row_q;
  bank_req_s   req_q;
  logic        req_vld_q;
  tick_t       wait_q;
  tick_t       ras_q;
  logic        take;
  logic        row_hit;
  logic        need_pre;

  assign take     = load_i & ~req_vld_q & ~ref_pending_i;
  assign row_hit  = req_vld_q && (req_q.row == row_q);
  // Close on a miss, or for refresh once no access is left
  assign need_pre = ~row_hit & (req_vld_q | ref_pending_i);

  always_comb begin
    cmd_o.valid = 1'b0;
    cmd_o.cmd   = DDR_NOP;
    cmd_o.bank  = bank_t'(BANK_ID);
    cmd_o.row   = req_q.row;
    cmd_o.col   = req_q.col;
    cmd_o.data  = req_q.data;
    case (state_q)
      BANK_IDLE: begin
        if (req_vld_q) begin
          cmd_o.valid = 1'b1;
          cmd_o.cmd   = DDR_ACT;
        end
      end
      BANK_ACTIVE: begin
        if (row_hit) begin
          cmd_o.valid = 1'b1;
          if (req_q.cmd == APP_CMD_READ) begin
            cmd_o.cmd = DDR_READ;
          end else begin
            cmd_o.cmd = DDR_WRITE;
          end
        end else if (need_pre && ras_q == '0) begin
          cmd_o.valid = 1'b1;
          cmd_o.cmd   = DDR_PRE;
          cmd_o.row   = row_q;
        end
      end
      default: cmd_o.valid = 1'b0;
    endcase
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (ui_clk_sync_rst) begin
      state_q   <= BANK_IDLE;
      req_vld_q <= 1'b0;
      wait_q    <= '0;
      ras_q     <= '0;
    end else begin
      wait_q <= tick_dec(wait_q);
      ras_q  <= tick_dec(ras_q);
      if (take) begin
        req_vld_q <= 1'b1;
      end
      case (state_q)
        BANK_IDLE: begin
          if (grant_i) begin
            state_q <= BANK_ACTIVATING;
            wait_q  <= tick_dec(timing_i.trcd);
            ras_q   <= tick_dec(timing_i.tras);
          end
        end
        BANK_ACTIVATING: begin
          // trcd from the activate
          if (wait_q <= tick_t'(1)) begin
            state_q <= BANK_ACTIVE;
          end
        end
        BANK_ACTIVE: begin
          if (grant_i && row_hit) begin
            req_vld_q <= 1'b0;
          end else if (grant_i) begin
            state_q <= BANK_PRECHARGING;
            wait_q  <= tick_dec(timing_i.trp);
          end
        end
        BANK_PRECHARGING: begin
          if (wait_q <= tick_t'(1)) begin
            state_q <= BANK_IDLE;
          end
        end
        default: state_q <= BANK_IDLE;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (take) begin
      req_q <= req_i;
    end
    if (state_q == BANK_IDLE && grant_i) begin
      row_q <= req_q.row;
    end
  end

  assign busy_o = req_vld_q;
  assign idle_o = (state_q == BANK_IDLE) & ~req_vld_q;

endmodule

// File: dmc_cmd_arbiter.sv
`timescale 1ns/1ps

module dmc_cmd_arbiter
  import dmc_pkg::*;
(
  input  logic                         dfi_clk_1x,
  input  logic                         ui_clk_sync_rst,
  input  dmc_timing_s                  timing_i,
  input  bank_cmd_s [NUM_BANKS_LP-1:0] bank_cmd_i,
  input  logic [NUM_BANKS_LP-1:0]      bank_idle_i,
  output logic [NUM_BANKS_LP-1:0]      grant_o,
  input  bank_t                        order_head_i,
  input  logic                         order_empty_i,
  output logic                         order_pop_o,
  output logic                         ref_pending_o,
  output logic                         refresh_in_progress_o,
  output ddr_bus_s                     ddr_o,
  input  data_t                        ddr_dq_i,
  output data_t                        app_rd_data_o,
  output logic                         app_rd_data_valid_o
);

  typedef enum logic [1:0] {
    REF_IDLE,
    REF_PEND,
    REF_WAIT
  } ref_state_e;

  ref_state_e            ref_state_q;
  refi_t                 refi_cnt_q;
  tick_t                 rfc_cnt_q;
  logic                  refi_wrap;
  logic                  ref_go;
  logic                  gnt_vld;
  bank_t                 gnt_idx;
  bank_cmd_s             gnt_cmd;
  ddr_bus_s              ddr_q;
  logic [RD_PIPE_LP-1:0] rd_pipe_q;

  function automatic logic is_col(ddr_cmd_e c);
    return (c == DDR_READ) || (c == DDR_WRITE);
  endfunction

  assign refi_wrap = (refi_cnt_q >= timing_i.trefi - 1'b1);
  assign ref_go    = (ref_state_q == REF_PEND) && (&bank_idle_i) && order_empty_i;

  // Column command only for the queue head, else lowest bank with ACT or PRE
  always_comb begin
    gnt_vld = 1'b0;
    gnt_idx = order_head_i;
    if (ref_state_q != REF_WAIT && !ref_go) begin
      if (!order_empty_i && bank_cmd_i[order_head_i].valid &&
          is_col(bank_cmd_i[order_head_i].cmd)) begin
        gnt_vld = 1'b1;
      end else begin
        for (int i = NUM_BANKS_LP - 1; i >= 0; i--) begin
          if (bank_cmd_i[i].valid && !is_col(bank_cmd_i[i].cmd)) begin
            gnt_vld = 1'b1;
            gnt_idx = bank_t'(i);
          end
        end
      end
    end
  end

  assign gnt_cmd = bank_cmd_i[gnt_idx];

  always_comb begin
    grant_o          = '0;
    grant_o[gnt_idx] = gnt_vld;
  end

  assign order_pop_o = gnt_vld & is_col(gnt_cmd.cmd);

  always_ff @(posedge dfi_clk_1x) begin
    ddr_q.ba   <= gnt_cmd.bank;
    ddr_q.addr <= is_col(gnt_cmd.cmd) ? row_t'(gnt_cmd.col) : gnt_cmd.row;
    ddr_q.dq   <= gnt_cmd.data;
    if (ui_clk_sync_rst) begin
      ddr_q.cmd   <= DDR_NOP;
      ddr_q.wr_en <= 1'b0;
    end else if (ref_go) begin
      ddr_q.cmd   <= DDR_REF;
      ddr_q.wr_en <= 1'b0;
    end else if (gnt_vld) begin
      ddr_q.cmd   <= gnt_cmd.cmd;
      ddr_q.wr_en <= (gnt_cmd.cmd == DDR_WRITE);
    end else begin
      ddr_q.cmd   <= DDR_NOP;
      ddr_q.wr_en <= 1'b0;
    end
  end

  always_ff @(posedge dfi_clk_1x) begin
    if (ui_clk_sync_rst) begin
      ref_state_q <= REF_IDLE;
      refi_cnt_q  <= '0;
      rfc_cnt_q   <= '0;
      rd_pipe_q   <= '0;
    end else begin
      // Bit 0 lines up with the read on the pins
      rd_pipe_q  <= {rd_pipe_q[RD_PIPE_LP-2:0], gnt_vld && (gnt_cmd.cmd == DDR_READ)};
      refi_cnt_q <= refi_wrap ? '0 : refi_cnt_q + 1'b1;
      case (ref_state_q)
        REF_IDLE: begin
          if (refi_wrap) begin
            ref_state_q <= REF_PEND;
          end
        end
        REF_PEND: begin
          if (ref_go) begin
            ref_state_q <= REF_WAIT;
            rfc_cnt_q   <= tick_dec(timing_i.trfc);
          end
        end
        REF_WAIT: begin
          rfc_cnt_q <= tick_dec(rfc_cnt_q);
          if (rfc_cnt_q <= tick_t'(1)) begin
            ref_state_q <= REF_IDLE;
          end
        end
        default: ref_state_q <= REF_IDLE;
      endcase
    end
  end

  assign ref_pending_o         = (ref_state_q != REF_IDLE);
  assign refresh_in_progress_o = (ref_state_q != REF_IDLE);
  assign ddr_o                 = ddr_q;
  assign app_rd_data_o         = ddr_dq_i;
  assign app_rd_data_valid_o   = rd_pipe_q[timing_i.tcas];

endmodule

// File: dmc_top.sv
`timescale 1ns/1ps

module dmc_top
  import dmc_pkg::*;
(
  input  logic                      dfi_clk_1x,
  input  logic                      ui_clk_sync_rst,
  input  logic [AXIL_ADDR_W_LP-1:0] s_axil_awaddr_i,
  input  logic                      s_axil_awvalid_i,
  output logic                      s_axil_awready_o,
  input  data_t                     s_axil_wdata_i,
  input  logic                      s_axil_wvalid_i,
  output logic                      s_axil_wready_o,
  output logic [1:0]                s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  logic                      s_axil_bready_i,
  input  logic [AXIL_ADDR_W_LP-1:0] s_axil_araddr_i,
  input  logic                      s_axil_arvalid_i,
  output logic                      s_axil_arready_o,
  output data_t                     s_axil_rdata_o,
  output logic [1:0]                s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  logic                      s_axil_rready_i,
  input  app_addr_t                 app_addr_i,
  input  app_cmd_e                  app_cmd_i,
  input  logic                      app_en_i,
  input  data_t                     app_wdf_data_i,
  output logic                      app_rdy_o,
  output data_t                     app_rd_data_o,
  output logic                      app_rd_data_valid_o,
  output logic                      refresh_in_progress_o,
  output ddr_bus_s                  ddr_o,
  input  data_t                     ddr_dq_i
);

  dmc_timing_s                  timing;
  logic                         ref_pending;
  logic [NUM_BANKS_LP-1:0]      bank_busy;
  logic [NUM_BANKS_LP-1:0]      bank_idle;
  logic [NUM_BANKS_LP-1:0]      bank_load;
  logic [NUM_BANKS_LP-1:0]      bank_grant;
  bank_req_s                    bank_req;
  bank_cmd_s [NUM_BANKS_LP-1:0] bank_cmd;
  logic                         order_pop;
  bank_t                        order_head;
  logic                         order_empty;

  dmc_cfg_regs cfg_regs_i (
    .dfi_clk_1x       (dfi_clk_1x),
    .ui_clk_sync_rst  (ui_clk_sync_rst),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .timing_o         (timing)
  );

  dmc_cmd_dispatch cmd_dispatch_i (
    .dfi_clk_1x      (dfi_clk_1x),
    .ui_clk_sync_rst (ui_clk_sync_rst),
    .app_addr_i      (app_addr_i),
    .app_cmd_i       (app_cmd_i),
    .app_en_i        (app_en_i),
    .app_wdf_data_i  (app_wdf_data_i),
    .app_rdy_o       (app_rdy_o),
    .ref_pending_i   (ref_pending),
    .bank_busy_i     (bank_busy),
    .bank_load_o     (bank_load),
    .bank_req_o      (bank_req),
    .order_pop_i     (order_pop),
    .order_head_o    (order_head),
    .order_empty_o   (order_empty)
  );

  for (genvar b = 0; b < NUM_BANKS_LP; b++) begin : g_bank
    dmc_bank_machine #(
      .BANK_ID (b)
    ) bank_machine_i (
      .dfi_clk_1x      (dfi_clk_1x),
      .ui_clk_sync_rst (ui_clk_sync_rst),
      .timing_i        (timing),
      .load_i          (bank_load[b]),
      .req_i           (bank_req),
      .ref_pending_i   (ref_pending),
      .grant_i         (bank_grant[b]),
      .busy_o          (bank_busy[b]),
      .idle_o          (bank_idle[b]),
      .cmd_o           (bank_cmd[b])
    );
  end

  dmc_cmd_arbiter cmd_arbiter_i (
    .dfi_clk_1x            (dfi_clk_1x),
    .ui_clk_sync_rst       (ui_clk_sync_rst),
    .timing_i              (timing),
    .bank_cmd_i            (bank_cmd),
    .bank_idle_i           (bank_idle),
    .grant_o               (bank_grant),
    .order_head_i          (order_head),
    .order_empty_i         (order_empty),
    .order_pop_o           (order_pop),
    .ref_pending_o         (ref_pending),
    .refresh_in_progress_o (refresh_in_progress_o),
    .ddr_o                 (ddr_o),
    .ddr_dq_i              (ddr_dq_i),
    .app_rd_data_o         (app_rd_data_o),
    .app_rd_data_valid_o   (app_rd_data_valid_o)
  );

endmodule

// File: tb_dram_model.sv
`timescale 1ns/1ps

module tb_dram_model
  import dmc_pkg::*;
(
  input  logic     dfi_clk_1x,
  input  logic     ui_clk_sync_rst,
  input  ddr_bus_s ddr_i,
  input  tick_t    trcd_i,
  input  tick_t    trp_i,
  input  tick_t    tcas_i,
  output data_t    dq_o,
  output int       err_cnt_o
);

  data_t     mem [app_addr_t];
  row_t      open_row [NUM_BANKS_LP];
  logic      open_vld [NUM_BANKS_LP];
  int        act_cyc [NUM_BANKS_LP];
  int        pre_cyc [NUM_BANKS_LP];
  data_t     dq_pipe [RD_PIPE_LP];
  int        cyc;
  app_addr_t key;
  data_t     rd_word;
  int        b;

  // Preload for never-written words
  function automatic data_t fill_word(app_addr_t a);
    return {a[9:0], a} ^ 32'h5a5a_5a5a;
  endfunction

  initial begin
    err_cnt_o = 0;
  end

  // Slot tcas-1 lines up with the controller's valid
  assign dq_o = dq_pipe[tick_t'(tcas_i - 1'b1)];

  always @(posedge dfi_clk_1x) begin
    rd_word = '0;
    if (ui_clk_sync_rst) begin
      cyc = 0;
      for (int i = 0; i < NUM_BANKS_LP; i++) begin
        open_vld[i] = 1'b0;
        act_cyc[i]  = -100;
        pre_cyc[i]  = -100;
      end
    end else begin
      cyc = cyc + 1;
      b   = int'(ddr_i.ba);
      key = {open_row[b], ddr_i.ba, ddr_i.addr[COL_W_LP-1:0]};
      // Write enable only with a write command
      assert (ddr_i.wr_en == (ddr_i.cmd == DDR_WRITE)) else begin
        err_cnt_o++;
        $display("Fail %0t ddr_o.wr_en got %0b exp %0b", $time, ddr_i.wr_en,
                 ddr_i.cmd == DDR_WRITE);
      end
      case (ddr_i.cmd)
        DDR_ACT: begin
          assert (!open_vld[b]) else begin
            err_cnt_o++;
            $display("Activate to bank %0d which already has an open row at %0t", b, $time);
          end
          assert (cyc - pre_cyc[b] >= int'(trp_i)) else begin
            err_cnt_o++;
            $display("Fail %0t trp bank %0d got %0d exp >= %0d", $time, b,
                     cyc - pre_cyc[b], trp_i);
          end
          open_vld[b] = 1'b1;
          open_row[b] = ddr_i.addr;
          act_cyc[b]  = cyc;
        end
        DDR_PRE: begin
          open_vld[b] = 1'b0;
          pre_cyc[b]  = cyc;
        end
        DDR_READ, DDR_WRITE: begin
          assert (open_vld[b]) else begin
            err_cnt_o++;
            $display("Column access to bank %0d with no open row at %0t", b, $time);
          end
          assert (cyc - act_cyc[b] >= int'(trcd_i)) else begin
            err_cnt_o++;
            $display("Fail %0t trcd bank %0d got %0d exp >= %0d", $time, b,
                     cyc - act_cyc[b], trcd_i);
          end
          if (ddr_i.cmd == DDR_WRITE) begin
            mem[key] = ddr_i.dq;
          end else begin
            rd_word = mem.exists(key) ? mem[key] : fill_word(key);
          end
        end
        DDR_REF: begin
          for (int i = 0; i < NUM_BANKS_LP; i++) begin
            assert (!open_vld[i]) else begin
              err_cnt_o++;
              $display("Refresh while bank %0d is open at %0t", i, $time);
            end
          end
        end
        default: ;
      endcase
    end
    dq_pipe[0] <= rd_word;
    for (int i = 1; i < RD_PIPE_LP; i++) begin
      dq_pipe[i] <= dq_pipe[i-1];
    end
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top
  import dmc_pkg::*;
;

  localparam int WAIT_LIMIT = 2000;

  logic                      clk;
  logic                      rst;
  logic [AXIL_ADDR_W_LP-1:0] awaddr;
  logic                      awvalid;
  logic                      awready;
  data_t                     wdata;
  logic                      wvalid;
  logic                      wready;
  logic [1:0]                bresp;
  logic                      bvalid;
  logic                      bready;
  logic [AXIL_ADDR_W_LP-1:0] araddr;
  logic                      arvalid;
  logic                      arready;
  data_t                     rdata;
  logic [1:0]                rresp;
  logic                      rvalid;
  logic                      rready;
  app_addr_t                 app_addr;
  app_cmd_e                  app_cmd;
  logic                      app_en;
  data_t                     app_wdf_data;
  logic                      app_rdy;
  data_t                     app_rd_data;
  logic                      app_rd_data_valid;
  logic                      rip;
  ddr_bus_s                  ddr;
  data_t                     ddr_dq;

  int    seed;
  int    err_cnt;
  int    model_err;
  int    cyc;
  int    rd_acc;
  int    rd_ret;
  int    acc_cnt;
  int    col_cnt;
  int    last_ref;
  int    trefi_prev;
  int    trefi_v;
  tick_t trcd_v;
  tick_t trp_v;
  tick_t tcas_v;
  data_t ref_mem [app_addr_t];
  data_t exp_q [$];
  int    rd_cmd_q [$];

  dmc_top dmc_top_i (
    .dfi_clk_1x            (clk),
    .ui_clk_sync_rst       (rst),
    .s_axil_awaddr_i       (awaddr),
    .s_axil_awvalid_i      (awvalid),
    .s_axil_awready_o      (awready),
    .s_axil_wdata_i        (wdata),
    .s_axil_wvalid_i       (wvalid),
    .s_axil_wready_o       (wready),
    .s_axil_bresp_o        (bresp),
    .s_axil_bvalid_o       (bvalid),
    .s_axil_bready_i       (bready),
    .s_axil_araddr_i       (araddr),
    .s_axil_arvalid_i      (arvalid),
    .s_axil_arready_o      (arready),
    .s_axil_rdata_o        (rdata),
    .s_axil_rresp_o        (rresp),
    .s_axil_rvalid_o       (rvalid),
    .s_axil_rready_i       (rready),
    .app_addr_i            (app_addr),
    .app_cmd_i             (app_cmd),
    .app_en_i              (app_en),
    .app_wdf_data_i        (app_wdf_data),
    .app_rdy_o             (app_rdy),
    .app_rd_data_o         (app_rd_data),
    .app_rd_data_valid_o   (app_rd_data_valid),
    .refresh_in_progress_o (rip),
    .ddr_o                 (ddr),
    .ddr_dq_i              (ddr_dq)
  );

  tb_dram_model dram_i (
    .dfi_clk_1x      (clk),
    .ui_clk_sync_rst (rst),
    .ddr_i           (ddr),
    .trcd_i          (trcd_v),
    .trp_i           (trp_v),
    .tcas_i          (tcas_v),
    .dq_o            (ddr_dq),
    .err_cnt_o       (model_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Same preload rule as the DRAM model
  function automatic data_t fill_word(app_addr_t a);
    return {a[9:0], a} ^ 32'h5a5a_5a5a;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("Fail %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout while waiting for %s at %0t", what, $time);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic axil_write(input logic [3:0] addr, input data_t data, output logic [1:0] resp);
    int t;
    t = 0;
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    do begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_on_timeout("AXI write address");
    end while (!awready);
    // Data is taken in the same cycle as the address
    check_eq("s_axil_wready_o", wready, 1'b1);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_on_timeout("AXI write response");
    end while (!bvalid);
    resp = bresp;
  endtask

  task automatic axil_read(input logic [3:0] addr, output data_t data, output logic [1:0] resp);
    int t;
    t = 0;
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_on_timeout("AXI read address");
    end while (!arready);
    arvalid <= 1'b0;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_on_timeout("AXI read data");
    end while (!rvalid);
    data = rdata;
    resp = rresp;
  endtask

  task automatic read_expect(input logic [3:0] addr, input data_t exp);
    data_t d;
    logic [1:0] r;
    axil_read(addr, d, r);
    check_eq("s_axil_rdata_o", d, exp);
    check_eq("s_axil_rresp_o", r, AXI_RESP_OKAY_LP);
  endtask

  task automatic issue_cmd(input app_cmd_e cmd, input app_addr_t addr, input data_t data);
    int t;
    t = 0;
    app_en       <= 1'b1;
    app_cmd      <= cmd;
    app_addr     <= addr;
    app_wdf_data <= data;
    do begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_on_timeout("app_rdy_o");
    end while (!app_rdy);
    app_en <= 1'b0;
  endtask

  // Three rows and four columns over all banks, or one bank in bursts
  task automatic run_traffic(input int n, input logic burst);
    bank_t ba;
    row_t  row;
    col_t  col;
    for (int i = 0; i < n; i++) begin
      if (!burst || (i % 16 == 0)) ba = bank_t'({$random(seed)} % NUM_BANKS_LP);
      row = row_t'({$random(seed)} % 3);
      col = col_t'({$random(seed)} % 4);
      if ({$random(seed)} % 4 == 0) begin
        repeat ({$random(seed)} % 3 + 1) @(posedge clk);
      end
      issue_cmd(($random(seed) & 1) ? APP_CMD_READ : APP_CMD_WRITE,
                {row, ba, col}, $random(seed));
    end
  endtask

  // Every accepted command on the pins and every read returned
  task automatic drain_traffic();
    int t;
    t = 0;
    while (exp_q.size() != 0 || rd_cmd_q.size() != 0 || col_cnt != acc_cnt) begin
      @(posedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_on_timeout("outstanding commands and read data");
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst) begin
      if (app_en && app_rdy) begin
        acc_cnt++;
        if (app_cmd == APP_CMD_WRITE) begin
          ref_mem[app_addr] = app_wdf_data;
        end else begin
          exp_q.push_back(ref_mem.exists(app_addr) ? ref_mem[app_addr] : fill_word(app_addr));
          rd_acc++;
        end
      end
      if (ddr.cmd == DDR_READ || ddr.cmd == DDR_WRITE) col_cnt++;
      if (ddr.cmd == DDR_READ) rd_cmd_q.push_back(cyc);
      if (app_rd_data_valid) begin
        rd_ret++;
        assert (exp_q.size() > 0 && rd_cmd_q.size() > 0) else begin
          err_cnt++;
          $display("Read data returned with no read outstanding at %0t", $time);
        end
        if (exp_q.size() > 0) check_eq("app_rd_data_o", app_rd_data, exp_q.pop_front());
        if (rd_cmd_q.size() > 0) begin
          check_eq("read latency", cyc - rd_cmd_q.pop_front(), int'(tcas_v));
        end
      end
      if (ddr.cmd == DDR_REF) begin
        assert (rip) else begin
          err_cnt++;
          $display("Refresh on the pins without refresh_in_progress_o at %0t", $time);
        end
        assert (cyc - last_ref <= (trefi_prev > trefi_v ? trefi_prev : trefi_v) + 64) else begin
          err_cnt++;
          $display("Refresh spacing of %0d cycles is too long at %0t", cyc - last_ref, $time);
        end
        last_ref   = cyc;
        trefi_prev = trefi_v;
      end
      assert (!(rip && app_rdy)) else begin
        err_cnt++;
        $display("app_rdy_o high during refresh at %0t", $time);
      end
    end
  end

  initial begin
    logic [1:0] r;
    data_t d;
    seed = 32'hb42;
    err_cnt = 0;
    cyc = 0;
    rd_acc = 0;
    rd_ret = 0;
    acc_cnt = 0;
    col_cnt = 0;
    last_ref = 0;
    trefi_v = 200;
    trefi_prev = 200;
    trcd_v = 4'd3;
    trp_v = 4'd3;
    tcas_v = 4'd3;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    app_addr = '0;
    app_cmd = APP_CMD_WRITE;
    app_en = 1'b0;
    app_wdf_data = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    read_expect(4'h0, 32'h33);
    read_expect(4'h4, 32'h36);
    read_expect(4'h8, 32'h08);
    read_expect(4'hc, 32'd200);

    run_traffic(150, 1'b0);
    drain_traffic();

    axil_write(4'h0, 32'h34, r);
    check_eq("s_axil_bresp_o", r, AXI_RESP_OKAY_LP);
    trcd_v = 4'd4;
    axil_write(4'h4, 32'h56, r);
    check_eq("s_axil_bresp_o", r, AXI_RESP_OKAY_LP);
    tcas_v = 4'd5;
    axil_write(4'hc, 32'd120, r);
    check_eq("s_axil_bresp_o", r, AXI_RESP_OKAY_LP);
    trefi_v = 120;
    read_expect(4'h0, 32'h34);
    read_expect(4'h4, 32'h56);
    read_expect(4'hc, 32'd120);
    axil_read(4'h2, d, r);
    check_eq("s_axil_rresp_o", r, AXI_RESP_SLVERR_LP);

    run_traffic(150, 1'b0);
    run_traffic(100, 1'b1);
    drain_traffic();
    check_eq("reads returned", rd_ret, rd_acc);
    assert (cyc - last_ref <= trefi_v + 64) else begin
      err_cnt++;
      $display("No refresh on the pins for the last %0d cycles at %0t", cyc - last_ref, $time);
    end

    $display("Errors: testbench %0d, DRAM model %0d; reads accepted %0d, returned %0d",
             err_cnt, model_err, rd_acc, rd_ret);
    if (err_cnt == 0 && model_err == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
dmc_pkg.sv
dmc_cfg_regs.sv
dmc_cmd_dispatch.sv
dmc_bank_machine.sv
dmc_cmd_arbiter.sv
dmc_top.sv
tb_dram_model.sv
tb_top.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f
./obj_dir/Vtb_top | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
else
  exit 1
fi
